//--- common/mem_stage_pkg.sv
// **********************************************************
// Memory stage package
// Datapath sizes, access-type codes, control register
// indices and the format-C instruction views
// **********************************************************
`default_nettype none

package mem_stage_pkg;

	localparam int NUM_LANES = 16;
	localparam int LANE_W = 32;
	localparam int LINE_W = 512;
	localparam int LINE_BYTES = 64;
	localparam int MEM_LINES = 64;
	localparam int LINE_IDX_W = 6;

	localparam logic [1:0] FMT_C = 2'b10;

	// First code of each group in bits 28..25
	localparam logic [3:0] OP_BYTE = 4'b0000;
	localparam logic [3:0] OP_HALF = 4'b0010;
	localparam logic [3:0] OP_WORD = 4'b0100;
	localparam logic [3:0] OP_CR = 4'b0110;
	localparam logic [3:0] OP_BLOCK = 4'b0111;
	localparam logic [3:0] OP_STRIDED = 4'b1010;
	localparam logic [3:0] OP_SCATTER = 4'b1101;

	localparam logic [4:0] CR_STRAND_ID = 5'd0;
	localparam logic [4:0] CR_SCRATCH = 5'd7;
	localparam logic [4:0] CR_STRAND_EN = 5'd30;
	localparam logic [4:0] CR_HALT = 5'd31;

	// Host port FSM
	localparam logic [1:0] HP_IDLE = 2'd0;
	localparam logic [1:0] HP_WAIT = 2'd1;
	localparam logic [1:0] HP_RESP = 2'd2;

	typedef struct packed {
		logic [1:0] fmt;
		logic is_load;
		logic [3:0] op;
		logic [24:0] rest;
	} mem_view_t;

	typedef struct packed {
		logic [1:0] fmt;
		logic is_load;
		logic [3:0] op;
		logic [19:0] rsvd;
		logic [4:0] idx;
	} cr_view_t;

	typedef union packed {
		mem_view_t mem;
		cr_view_t cr;
	} instr_u;

	function automatic logic [31:0] bswap32(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

`default_nettype wire

//--- design/line_memory/line_memory.sv
// **********************************************************
// Line memory
// 64 lines of 512 bits, byte write mask, registered read
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module line_memory (
	input wire clk,
	input wire rst_n_i,
	input wire en_i,
	input wire we_i,
	input wire [mem_stage_pkg::LINE_IDX_W-1:0] line_i,
	input wire [mem_stage_pkg::LINE_W-1:0] wdata_i,
	input wire [mem_stage_pkg::LINE_BYTES-1:0] wmask_i,
	output logic [mem_stage_pkg::LINE_W-1:0] rdata_o
);

	logic [mem_stage_pkg::LINE_W-1:0] mem_q [mem_stage_pkg::MEM_LINES];

	always_ff @(posedge clk)
	begin
		if (en_i && we_i)
		begin
			for (int b = 0; b < mem_stage_pkg::LINE_BYTES; b++)
			begin
				if (wmask_i[b])
					mem_q[line_i][8*b +: 8] <= wdata_i[8*b +: 8];
			end
		end
	end

	// Old contents on a write
	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			rdata_o <= '0;
		else if (en_i)
			rdata_o <= mem_q[line_i];
	end

endmodule

`default_nettype wire

//--- design/memory_access_stage/memory_access_stage.sv
// **********************************************************
// Memory access stage
// Address generation, store alignment and byte masks for
// format-C accesses, control registers, pipeline registers
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module memory_access_stage #(
	parameter logic [29:0] core_id = 30'd0
) (
	input wire clk,
	input wire rst_n_i,
	input wire [31:0] instruction_i,
	input wire [1:0] strand_id_i,
	input wire flush_i,
	input wire [31:0] pc_i,
	input wire [mem_stage_pkg::LINE_W-1:0] store_value_i,
	input wire [mem_stage_pkg::LINE_W-1:0] result_i,
	input wire [mem_stage_pkg::NUM_LANES-1:0] mask_i,
	input wire [3:0] reg_lane_select_i,
	input wire [31:0] base_addr_i,
	input wire [31:0] strided_offset_i,
	input wire has_writeback_i,
	input wire [6:0] writeback_reg_i,
	input wire writeback_is_vector_i,
	output logic dreq_o,
	output logic dwrite_o,
	output logic [31:0] daddress_o,
	output logic [mem_stage_pkg::LINE_W-1:0] ddata_o,
	output logic [mem_stage_pkg::LINE_BYTES-1:0] write_mask_o,
	output logic [31:0] instruction_o,
	output logic [1:0] strand_id_o,
	output logic [31:0] pc_o,
	output logic [mem_stage_pkg::LINE_W-1:0] result_o,
	output logic [mem_stage_pkg::NUM_LANES-1:0] mask_o,
	output logic [3:0] reg_lane_select_o,
	output logic [31:0] strided_offset_o,
	output logic has_writeback_o,
	output logic [6:0] writeback_reg_o,
	output logic writeback_is_vector_o,
	output logic [3:0] cache_lane_select_o,
	output logic [3:0] strand_enable_o,
	output logic was_access_o
);

	mem_stage_pkg::instr_u instr;
	logic [3:0] op;
	logic is_fmt_c, is_cr, is_byte, is_half, is_block, is_strided, is_scatter;
	logic lane_on, cr_write;
	logic [31:0] scalar_value, lane_value, strided_ptr, gather_ptr, ptr, word_data;
	logic [3:0] byte_mask;
	logic [15:0] word_mask;
	logic [mem_stage_pkg::LINE_W-1:0] swapped_vec, result_nxt;
	logic [31:0] scratch_q;

	assign instr = instruction_i;
	assign op = instr.mem.op;
	assign is_fmt_c = instr.mem.fmt == mem_stage_pkg::FMT_C;
	assign is_cr = is_fmt_c && op == mem_stage_pkg::OP_CR;
	assign is_byte = op < mem_stage_pkg::OP_HALF;
	assign is_half = op >= mem_stage_pkg::OP_HALF && op < mem_stage_pkg::OP_WORD;
	assign is_block = op >= mem_stage_pkg::OP_BLOCK && op < mem_stage_pkg::OP_STRIDED;
	assign is_strided = op >= mem_stage_pkg::OP_STRIDED && op < mem_stage_pkg::OP_SCATTER;
	assign is_scatter = op >= mem_stage_pkg::OP_SCATTER;

	// Lane 0 is the top word, mask bit 15
	assign lane_on = mask_i[mem_stage_pkg::NUM_LANES - 1 - reg_lane_select_i];
	assign scalar_value = store_value_i[mem_stage_pkg::LINE_W-1 -: 32];
	assign lane_value = store_value_i[(15 - reg_lane_select_i) * 32 +: 32];
	assign gather_ptr = result_i[(15 - reg_lane_select_i) * 32 +: 32];
	assign strided_ptr = base_addr_i + strided_offset_i;

	always_comb
	begin
		if (is_strided)
			ptr = strided_ptr;
		else if (is_scatter)
			ptr = gather_ptr;
		else
			ptr = result_i[mem_stage_pkg::LINE_W-1 -: 32];	// Scalar and block use lane 0
	end

	// Per-lane accesses need their mask bit
	assign dreq_o = is_fmt_c && !is_cr && !flush_i
		&& (lane_on || !(is_strided || is_scatter));
	assign dwrite_o = dreq_o && !instr.mem.is_load;
	assign daddress_o = {ptr[31:6], 6'd0};

	always_comb
	begin
		if (is_block)
			word_mask = mask_i;
		else if ((is_strided || is_scatter) && !lane_on)
			word_mask = '0;
		else
			word_mask = 16'h8000 >> ptr[5:2];
	end

	always_comb
	begin
		byte_mask = 4'b1111;
		word_data = mem_stage_pkg::bswap32(lane_value);
		if (is_byte)
		begin
			byte_mask = 4'b1000 >> ptr[1:0];
			word_data = {4{scalar_value[7:0]}};
		end
		else if (is_half)
		begin
			byte_mask = ptr[1] ? 4'b0011 : 4'b1100;
			word_data = {2{scalar_value[7:0], scalar_value[15:8]}};
		end
		else if (!(is_strided || is_scatter))
			word_data = mem_stage_pkg::bswap32(scalar_value);
	end

	always_comb
	begin
		for (int i = 0; i < mem_stage_pkg::NUM_LANES; i++)
			swapped_vec[i*32 +: 32] = mem_stage_pkg::bswap32(store_value_i[i*32 +: 32]);
	end

	assign ddata_o = is_block ? swapped_vec : {16{word_data}};

	always_comb
	begin
		for (int i = 0; i < mem_stage_pkg::NUM_LANES; i++)
			write_mask_o[4*i +: 4] = {4{word_mask[i]}} & byte_mask;
	end

	// Control register reads land in lane 0
	always_comb
	begin
		result_nxt = result_i;
		if (is_cr)
		begin
			result_nxt = '0;
			case (instr.cr.idx)
				mem_stage_pkg::CR_STRAND_ID: result_nxt[511 -: 32] = {core_id, strand_id_i};
				mem_stage_pkg::CR_SCRATCH: result_nxt[511 -: 32] = scratch_q;
				mem_stage_pkg::CR_STRAND_EN: result_nxt[511 -: 32] = {28'd0, strand_enable_o};
				default: ;
			endcase
		end
	end

	assign cr_write = is_cr && !instr.mem.is_load && !flush_i;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			scratch_q <= '0;
			strand_enable_o <= 4'b0001;
			was_access_o <= 1'b0;
			instruction_o <= '0;
			has_writeback_o <= 1'b0;
		end
		else
		begin
			if (cr_write)
			begin
				case (instr.cr.idx)
					mem_stage_pkg::CR_SCRATCH: scratch_q <= scalar_value;
					mem_stage_pkg::CR_STRAND_EN: strand_enable_o <= scalar_value[3:0];
					mem_stage_pkg::CR_HALT: strand_enable_o <= '0;
					default: ;
				endcase
			end
			was_access_o <= dreq_o;
			instruction_o <= flush_i ? '0 : instruction_i;	// Squashed slot
			has_writeback_o <= has_writeback_i && !flush_i;
		end
	end

	always_ff @(posedge clk)
	begin
		strand_id_o <= strand_id_i;
		pc_o <= pc_i;
		result_o <= result_nxt;
		mask_o <= mask_i;
		reg_lane_select_o <= reg_lane_select_i;
		strided_offset_o <= strided_offset_i;
		writeback_reg_o <= writeback_reg_i;
		writeback_is_vector_o <= writeback_is_vector_i;
		cache_lane_select_o <= ptr[5:2];
	end

	// A masked-off lane writes no byte
	a_lane_off_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		(is_strided || is_scatter) && !lane_on |-> write_mask_o == '0);

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
// **********************************************************
// Memory arbiter
// Fixed priority, the stage ahead of the host port
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input wire clk,
	input wire rst_n_i,
	input wire dreq_i,
	input wire dwrite_i,
	input wire [31:0] daddress_i,
	input wire [mem_stage_pkg::LINE_W-1:0] ddata_i,
	input wire [mem_stage_pkg::LINE_BYTES-1:0] write_mask_i,
	input wire hreq_i,
	input wire hwrite_i,
	input wire [mem_stage_pkg::LINE_IDX_W-1:0] haddr_i,
	input wire [mem_stage_pkg::LINE_W-1:0] hdata_i,
	input wire [mem_stage_pkg::LINE_BYTES-1:0] hmask_i,
	output logic hgrant_o,
	output logic mem_en_o,
	output logic mem_we_o,
	output logic [mem_stage_pkg::LINE_IDX_W-1:0] mem_line_o,
	output logic [mem_stage_pkg::LINE_W-1:0] mem_wdata_o,
	output logic [mem_stage_pkg::LINE_BYTES-1:0] mem_wmask_o
);

	assign hgrant_o = hreq_i && !dreq_i;
	assign mem_en_o = dreq_i || hreq_i;

	always_comb
	begin
		if (dreq_i)
		begin
			mem_we_o = dwrite_i;
			mem_line_o = daddress_i[mem_stage_pkg::LINE_IDX_W+5:6];
			mem_wdata_o = ddata_i;
			mem_wmask_o = write_mask_i;
		end
		else
		begin
			mem_we_o = hwrite_i && hreq_i;
			mem_line_o = haddr_i;
			mem_wdata_o = hdata_i;
			mem_wmask_o = hmask_i;
		end
	end

	a_stage_first: assert property (@(posedge clk) disable iff (!rst_n_i)
		dreq_i |-> !hgrant_o);

	// A refused host request is held for the next cycle
	a_host_holds: assert property (@(posedge clk) disable iff (!rst_n_i)
		hreq_i && !hgrant_o |=> hreq_i && $stable(haddr_i));

endmodule

`default_nettype wire

//--- design/apb_host_port.sv
// **********************************************************
// APB host port
// 32-bit word transfers as masked line accesses
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
	input wire clk,
	input wire rst_n_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [11:0] paddr_i,
	input wire [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic hreq_o,
	output logic hwrite_o,
	output logic [mem_stage_pkg::LINE_IDX_W-1:0] haddr_o,
	output logic [mem_stage_pkg::LINE_W-1:0] hdata_o,
	output logic [mem_stage_pkg::LINE_BYTES-1:0] hmask_o,
	input wire hgrant_i,
	input wire [mem_stage_pkg::LINE_W-1:0] rdata_i
);

	logic [1:0] state_q, state_d;
	logic [3:0] lane;

	assign lane = paddr_i[5:2];
	assign hreq_o = state_q == mem_stage_pkg::HP_WAIT && psel_i && penable_i;
	assign hwrite_o = pwrite_i;
	assign haddr_o = paddr_i[11:6];
	assign hdata_o = {16{mem_stage_pkg::bswap32(pwdata_i)}};
	assign hmask_o = 64'hf000_0000_0000_0000 >> {lane, 2'b00};
	assign prdata_o = mem_stage_pkg::bswap32(rdata_i[(15 - lane) * 32 +: 32]);
	assign pready_o = state_q == mem_stage_pkg::HP_RESP;	// Line read is back here

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			mem_stage_pkg::HP_IDLE:
				if (psel_i && !penable_i)
					state_d = mem_stage_pkg::HP_WAIT;
			mem_stage_pkg::HP_WAIT:
				if (hreq_o && hgrant_i)
					state_d = mem_stage_pkg::HP_RESP;
				else if (!psel_i)
					state_d = mem_stage_pkg::HP_IDLE;
			default:
				state_d = mem_stage_pkg::HP_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			state_q <= mem_stage_pkg::HP_IDLE;
		else
			state_q <= state_d;
	end

	a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n_i)
		pready_o |-> psel_i && penable_i);

endmodule

`default_nettype wire

//--- design/mem_subsystem_top.sv
// **********************************************************
// Memory subsystem top
// Stage and APB host port sharing one line memory
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top #(
	parameter logic [29:0] core_id = 30'd0
) (
	input wire clk,
	input wire rst_n_i,
	input wire [31:0] instruction_i,
	input wire [1:0] strand_id_i,
	input wire flush_i,
	input wire [31:0] pc_i,
	input wire [mem_stage_pkg::LINE_W-1:0] store_value_i,
	input wire [mem_stage_pkg::LINE_W-1:0] result_i,
	input wire [mem_stage_pkg::NUM_LANES-1:0] mask_i,
	input wire [3:0] reg_lane_select_i,
	input wire [31:0] base_addr_i,
	input wire [31:0] strided_offset_i,
	input wire has_writeback_i,
	input wire [6:0] writeback_reg_i,
	input wire writeback_is_vector_i,
	output logic [31:0] instruction_o,
	output logic [1:0] strand_id_o,
	output logic [31:0] pc_o,
	output logic [mem_stage_pkg::LINE_W-1:0] result_o,
	output logic [mem_stage_pkg::NUM_LANES-1:0] mask_o,
	output logic [3:0] reg_lane_select_o,
	output logic [31:0] strided_offset_o,
	output logic has_writeback_o,
	output logic [6:0] writeback_reg_o,
	output logic writeback_is_vector_o,
	output logic [3:0] cache_lane_select_o,
	output logic [3:0] strand_enable_o,
	output logic was_access_o,
	output logic [mem_stage_pkg::LINE_W-1:0] dload_data_o,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input wire [11:0] paddr_i,
	input wire [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o
);

	logic stage_req, stage_we;
	logic [31:0] stage_addr;
	logic [mem_stage_pkg::LINE_W-1:0] stage_data, host_data, mem_wdata;
	logic [mem_stage_pkg::LINE_BYTES-1:0] stage_mask, host_mask, mem_wmask;
	logic host_req, host_we, host_grant;
	logic [mem_stage_pkg::LINE_IDX_W-1:0] host_line, mem_line;
	logic mem_en, mem_we;

	memory_access_stage #(
		.core_id(core_id)
	) u_stage (
		.clk, .rst_n_i, .instruction_i, .strand_id_i, .flush_i, .pc_i,
		.store_value_i, .result_i, .mask_i, .reg_lane_select_i,
		.base_addr_i, .strided_offset_i,
		.has_writeback_i, .writeback_reg_i, .writeback_is_vector_i,
		.dreq_o(stage_req),
		.dwrite_o(stage_we),
		.daddress_o(stage_addr),
		.ddata_o(stage_data),
		.write_mask_o(stage_mask),
		.instruction_o, .strand_id_o, .pc_o, .result_o, .mask_o,
		.reg_lane_select_o, .strided_offset_o,
		.has_writeback_o, .writeback_reg_o, .writeback_is_vector_o,
		.cache_lane_select_o, .strand_enable_o, .was_access_o
	);

	apb_host_port u_host (
		.clk, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
		.prdata_o, .pready_o,
		.hreq_o(host_req),
		.hwrite_o(host_we),
		.haddr_o(host_line),
		.hdata_o(host_data),
		.hmask_o(host_mask),
		.hgrant_i(host_grant),
		.rdata_i(dload_data_o)
	);

	mem_arbiter u_arb (
		.clk, .rst_n_i,
		.dreq_i(stage_req),
		.dwrite_i(stage_we),
		.daddress_i(stage_addr),
		.ddata_i(stage_data),
		.write_mask_i(stage_mask),
		.hreq_i(host_req),
		.hwrite_i(host_we),
		.haddr_i(host_line),
		.hdata_i(host_data),
		.hmask_i(host_mask),
		.hgrant_o(host_grant),
		.mem_en_o(mem_en),
		.mem_we_o(mem_we),
		.mem_line_o(mem_line),
		.mem_wdata_o(mem_wdata),
		.mem_wmask_o(mem_wmask)
	);

	line_memory u_mem (
		.clk, .rst_n_i,
		.en_i(mem_en),
		.we_i(mem_we),
		.line_i(mem_line),
		.wdata_i(mem_wdata),
		.wmask_i(mem_wmask),
		.rdata_o(dload_data_o)	// Shared by stage and host
	);

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// **********************************************************
// Testbench clock and reset
// 10 ns clock, reset held low for 5 cycles
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial
	begin
		rst_n_o = 1'b0;
		repeat (5) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;	// Released away from the rising edge
	end

endmodule

`default_nettype wire

//--- verification/tb_mem_subsystem.sv
// **********************************************************
// Memory subsystem testbench
// Directed tests of the stage and APB host port against a
// byte-level reference model of the line memory
// **********************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

	localparam logic [29:0] CORE_ID = 30'h0a5c_3e1;
	// Tests need a few hundred cycles
	localparam int CYCLE_LIMIT = 2000;

	logic clk, rst_n_i;
	logic [31:0] instruction_i, pc_i, base_addr_i, strided_offset_i;
	logic [1:0] strand_id_i;
	logic flush_i, has_writeback_i, writeback_is_vector_i;
	logic [511:0] store_value_i, result_i;
	logic [15:0] mask_i;
	logic [3:0] reg_lane_select_i;
	logic [6:0] writeback_reg_i;
	logic [31:0] instruction_o, pc_o, strided_offset_o;
	logic [1:0] strand_id_o;
	logic [511:0] result_o, dload_data_o;
	logic [15:0] mask_o;
	logic [3:0] reg_lane_select_o, cache_lane_select_o, strand_enable_o;
	logic has_writeback_o, writeback_is_vector_o, was_access_o;
	logic [6:0] writeback_reg_o;
	logic psel_i, penable_i, pwrite_i, pready_o;
	logic [11:0] paddr_i;
	logic [31:0] pwdata_i, prdata_o;

	logic [7:0] ref_mem [4096];	// Byte address order
	integer seed;
	int cycles = 0;
	int fail_count = 0;
	int ready_cycle, burst_end;

	tb_clock_gen u_clk_gen (
		.clk_o(clk),
		.rst_n_o(rst_n_i)
	);

	mem_subsystem_top #(
		.core_id(CORE_ID)
	) DUT (.*);

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$fatal(1);
		end
	end

	task automatic check(input string name, input logic [511:0] expected,
		input logic [511:0] actual);
		if (actual !== expected)
		begin
			fail_count++;
			$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// Little-endian bytes in address order
	function automatic void store_model(input logic [31:0] addr, input logic [31:0] value,
		input int nbytes);
		for (int k = 0; k < nbytes; k++)
			ref_mem[addr + k] = value[8*k +: 8];
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return {ref_mem[addr + 3], ref_mem[addr + 2], ref_mem[addr + 1], ref_mem[addr]};
	endfunction

	// Address offset 0 sits in the top byte of the line
	function automatic logic [511:0] expected_line(input int line);
		logic [511:0] l;
		for (int b = 0; b < 64; b++)
			l[8*b +: 8] = ref_mem[line * 64 + 63 - b];
		return l;
	endfunction

	function automatic logic [31:0] make_instr(input logic [3:0] op, input logic is_load,
		input logic [4:0] idx);
		mem_stage_pkg::instr_u u;
		u = '0;
		u.mem.fmt = mem_stage_pkg::FMT_C;
		u.mem.is_load = is_load;
		u.mem.op = op;
		u.cr.idx = idx;
		return u;
	endfunction

	// One instruction for one cycle, registered outputs valid on return
	task automatic issue(input logic [31:0] instr);
		@(negedge clk);
		instruction_i = instr;
		@(negedge clk);
		instruction_i = '0;
	endtask

	task automatic write_word_apb(input logic [31:0] addr, input logic [31:0] value);
		@(negedge clk);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b1;
		paddr_i = addr[11:0];
		pwdata_i = value;
		@(negedge clk);
		penable_i = 1'b1;
		@(negedge clk);
		while (!pready_o)
			@(negedge clk);
		ready_cycle = cycles;
		@(negedge clk);
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		store_model(addr, value, 4);
	endtask

	task automatic read_word_apb(input logic [31:0] addr, output logic [31:0] data);
		@(negedge clk);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = addr[11:0];
		@(negedge clk);
		penable_i = 1'b1;
		@(negedge clk);
		while (!pready_o)
			@(negedge clk);
		ready_cycle = cycles;
		data = prdata_o;
		@(negedge clk);
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic store_scalar(input logic [3:0] op, input logic [31:0] addr,
		input logic [31:0] value);
		logic [31:0] instr;
		instr = make_instr(op, 1'b0, 5'd0);
		result_i[511 -: 32] = addr;
		store_value_i[511 -: 32] = value;
		issue(instr);
		check("scalar_access", 1'b1, was_access_o);
		check("scalar_instr_pass", instr, instruction_o);
	endtask

	task automatic reset_values;
		check("reset_was_access", 1'b0, was_access_o);
		check("reset_instruction", 32'd0, instruction_o);
		check("reset_writeback", 1'b0, has_writeback_o);
		check("reset_pready", 1'b0, pready_o);
		check("reset_strand_en", 4'b0001, strand_enable_o);
	endtask

	// Word load at 0x1c8 sits in lane 2 of its line
	task automatic pipeline_fields;
		logic [31:0] pc, offs;
		pc = $random(seed);
		offs = $random(seed);
		pc_i = pc;
		strided_offset_i = offs;
		strand_id_i = 2'd1;
		mask_i = 16'h5a3c;
		reg_lane_select_i = 4'd9;
		has_writeback_i = 1'b1;
		writeback_reg_i = 7'h2b;
		writeback_is_vector_i = 1'b1;
		result_i[511 -: 32] = 32'h1c8;
		issue(make_instr(mem_stage_pkg::OP_WORD, 1'b1, 5'd0));
		check("pipe_access", 1'b1, was_access_o);
		check("pipe_pc", pc, pc_o);
		check("pipe_offset", offs, strided_offset_o);
		check("pipe_strand", 2'd1, strand_id_o);
		check("pipe_mask", 16'h5a3c, mask_o);
		check("pipe_lane_sel", 4'd9, reg_lane_select_o);
		check("pipe_writeback", 1'b1, has_writeback_o);
		check("pipe_wb_reg", 7'h2b, writeback_reg_o);
		check("pipe_wb_vector", 1'b1, writeback_is_vector_o);
		check("pipe_cache_lane", 4'd2, cache_lane_select_o);
		check("pipe_result", result_i, result_o);
		pc_i = '0;
		strided_offset_i = '0;
		strand_id_i = '0;
		mask_i = 16'hffff;
		reg_lane_select_i = '0;
		has_writeback_i = 1'b0;
		writeback_reg_i = '0;
		writeback_is_vector_i = 1'b0;
	endtask

	task automatic scalar_merge;
		logic [31:0] addr, wval, bval, hval, got;
		addr = 32'h88;
		wval = $random(seed);
		bval = $random(seed);
		hval = $random(seed);
		store_scalar(mem_stage_pkg::OP_WORD, addr, wval);
		store_model(addr, wval, 4);
		store_scalar(mem_stage_pkg::OP_BYTE, addr + 1, bval);
		store_model(addr + 1, bval, 1);
		store_scalar(mem_stage_pkg::OP_HALF, addr + 2, hval);
		store_model(addr + 2, hval, 2);
		read_word_apb(addr, got);
		check("scalar_merge", expected_word(addr), got);
	endtask

	task automatic block_masked_store;
		logic [31:0] base, got;
		logic [15:0] lanes;
		base = 32'h100;
		for (int l = 0; l < 16; l++)
			write_word_apb(base + 4 * l, $random(seed));
		lanes = $random(seed);
		for (int l = 0; l < 16; l++)
		begin
			store_value_i[(15 - l) * 32 +: 32] = $random(seed);
			if (lanes[15 - l])
				store_model(base + 4 * l, store_value_i[(15 - l) * 32 +: 32], 4);
		end
		mask_i = lanes;
		result_i[511 -: 32] = base + 32'h14;	// Offset inside the line
		issue(make_instr(mem_stage_pkg::OP_BLOCK, 1'b0, 5'd0));
		check("block_store_access", 1'b1, was_access_o);
		for (int l = 0; l < 16; l++)
		begin
			read_word_apb(base + 4 * l, got);
			check("block_store_lane", expected_word(base + 4 * l), got);
		end
		issue(make_instr(mem_stage_pkg::OP_BLOCK, 1'b1, 5'd0));
		check("block_load_access", 1'b1, was_access_o);
		check("block_load_line", expected_line(base[11:6]), dload_data_o);
	endtask

	task automatic strided_and_scatter;
		logic [31:0] addr, got;
		for (int l = 0; l < 16; l++)
			store_value_i[(15 - l) * 32 +: 32] = $random(seed);
		base_addr_i = 32'h200;
		mask_i = 16'hdfff;	// Lane 2 off
		for (int l = 0; l < 4; l++)
		begin
			addr = 32'h200 + 12 * l;
			write_word_apb(addr, $random(seed));
			strided_offset_i = 12 * l;
			reg_lane_select_i = 4'(l);
			issue(make_instr(mem_stage_pkg::OP_STRIDED, 1'b0, 5'd0));
			check("strided_access", mask_i[15 - l], was_access_o);
			if (mask_i[15 - l])
				store_model(addr, store_value_i[(15 - l) * 32 +: 32], 4);
			read_word_apb(addr, got);
			check("strided_word", expected_word(addr), got);
		end
		mask_i = 16'hbfff;	// Lane 1 off
		for (int l = 0; l < 4; l++)
		begin
			addr = 32'h240 + ((l * 7 + 3) % 16) * 4;
			write_word_apb(addr, $random(seed));
			result_i[(15 - l) * 32 +: 32] = addr;
			reg_lane_select_i = 4'(l);
			issue(make_instr(mem_stage_pkg::OP_SCATTER, 1'b0, 5'd0));
			check("scatter_access", mask_i[15 - l], was_access_o);
			if (mask_i[15 - l])
				store_model(addr, store_value_i[(15 - l) * 32 +: 32], 4);
			read_word_apb(addr, got);
			check("scatter_word", expected_word(addr), got);
		end
		mask_i = 16'hffff;
	endtask

	task automatic control_registers;
		logic [31:0] v;
		v = $random(seed);
		store_value_i[511 -: 32] = v;
		issue(make_instr(mem_stage_pkg::OP_CR, 1'b0, mem_stage_pkg::CR_SCRATCH));
		check("cr_no_access", 1'b0, was_access_o);
		issue(make_instr(mem_stage_pkg::OP_CR, 1'b1, mem_stage_pkg::CR_SCRATCH));
		check("scratch_readback", {v, 480'd0}, result_o);
		strand_id_i = 2'd2;
		issue(make_instr(mem_stage_pkg::OP_CR, 1'b1, mem_stage_pkg::CR_STRAND_ID));
		check("strand_id", {CORE_ID, 2'd2, 480'd0}, result_o);
		store_value_i[511 -: 32] = 32'h0000_000b;
		issue(make_instr(mem_stage_pkg::OP_CR, 1'b0, mem_stage_pkg::CR_STRAND_EN));
		check("strand_en_write", 4'hb, strand_enable_o);
		issue(make_instr(mem_stage_pkg::OP_CR, 1'b1, mem_stage_pkg::CR_STRAND_EN));
		check("strand_en_read", {28'd0, 4'hb, 480'd0}, result_o);
		issue(make_instr(mem_stage_pkg::OP_CR, 1'b0, mem_stage_pkg::CR_HALT));
		check("halt", 4'h0, strand_enable_o);
	endtask

	task automatic flushed_store;
		logic [31:0] addr, got;
		addr = 32'h88;
		flush_i = 1'b1;
		has_writeback_i = 1'b1;
		result_i[511 -: 32] = addr;
		store_value_i[511 -: 32] = $random(seed);
		issue(make_instr(mem_stage_pkg::OP_WORD, 1'b0, 5'd0));
		check("flush_instruction", 32'd0, instruction_o);
		check("flush_writeback", 1'b0, has_writeback_o);
		check("flush_access", 1'b0, was_access_o);
		flush_i = 1'b0;
		has_writeback_i = 1'b0;
		read_word_apb(addr, got);
		check("flush_memory", expected_word(addr), got);
	endtask

	// Word stores in back-to-back cycles
	task automatic store_burst(input logic [31:0] base, input int count);
		logic [31:0] v;
		for (int k = 0; k < count; k++)
		begin
			@(negedge clk);
			check("burst_pready_low", 1'b0, pready_o);
			v = $random(seed);
			result_i[511 -: 32] = base + 4 * k;
			store_value_i[511 -: 32] = v;
			instruction_i = make_instr(mem_stage_pkg::OP_WORD, 1'b0, 5'd0);
			store_model(base + 4 * k, v, 4);
		end
		@(negedge clk);
		check("burst_pready_low", 1'b0, pready_o);
		instruction_i = '0;
		burst_end = cycles;
	endtask

	task automatic host_backpressure;
		logic [31:0] v, got;
		v = $random(seed);
		fork
			store_burst(32'h300, 6);
			write_word_apb(32'h340, v);
		join
		check("bp_write_after_burst", 1'b1, ready_cycle > burst_end);
		fork
			store_burst(32'h380, 6);
			read_word_apb(32'h340, got);
		join
		check("bp_read_after_burst", 1'b1, ready_cycle > burst_end);
		check("bp_read_data", expected_word(32'h340), got);
		read_word_apb(32'h308, got);
		check("bp_burst_word", expected_word(32'h308), got);
	endtask

	initial
	begin
		seed = 87797;
		instruction_i = '0;
		strand_id_i = '0;
		flush_i = 1'b0;
		pc_i = '0;
		store_value_i = '0;
		result_i = '0;
		mask_i = 16'hffff;
		reg_lane_select_i = '0;
		base_addr_i = '0;
		strided_offset_i = '0;
		has_writeback_i = 1'b0;
		writeback_reg_i = '0;
		writeback_is_vector_i = 1'b0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		@(posedge rst_n_i);
		reset_values();
		pipeline_fields();
		scalar_merge();
		block_masked_store();
		strided_and_scatter();
		control_registers();
		flushed_store();
		host_backpressure();
		@(negedge clk);
		if (fail_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
common/mem_stage_pkg.sv
design/line_memory/line_memory.sv
design/memory_access_stage/memory_access_stage.sv
design/mem_arbiter.sv
design/apb_host_port.sv
design/mem_subsystem_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_subsystem.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - common/mem_stage_pkg.sv
  - design/line_memory/line_memory.sv
  - design/memory_access_stage/memory_access_stage.sv
  - design/mem_arbiter.sv
  - design/apb_host_port.sv
  - design/mem_subsystem_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_mem_subsystem.sv
